// ==== verilog/sd_proto_pkg.sv ====
// ===========================================================================
// sd command frame definitions
// ===========================================================================
package sd_proto_pkg;

    // command index, six bits after start and transmission bits
    typedef logic [5:0] sd_index_t;

    // 32-bit command argument
    typedef logic [31:0] sd_arg_t;

    // crc7 value, sent just ahead of the end bit
    typedef logic [6:0] sd_crc_t;

    // index and argument only
    // start, transmission, crc and end bits are framed by the serializer
    typedef struct packed {
        sd_index_t index;
        sd_arg_t   arg;
    } sd_cmd_t;

    // preamble flag set means dummy clocks, cmd is ignored then
    typedef struct packed {
        logic    preamble;
        sd_cmd_t cmd;
    } sd_req_t;

    // full frame length on the cmd line
    localparam int unsigned SD_FRAME_BITS = 48;

    // x^7 + x^3 + 1
    localparam sd_crc_t SD_CRC_POLY = 7'h09;

    // init command set
    localparam sd_index_t SD_CMD0   = 6'd0;
    localparam sd_index_t SD_CMD55  = 6'd55;
    localparam sd_index_t SD_ACMD41 = 6'd41;

    // hcs bit, host supports high capacity cards
    localparam sd_arg_t SD_ACMD41_ARG = 32'h4000_0000;

endpackage

// ==== verilog/board_pkg.sv ====
// ===========================================================================
// board level defaults for the 50 MHz card
// ===========================================================================
package board_pkg;

    // one ascii character for the debug port
    typedef logic [7:0] dbg_char_t;

    // half period of the sd clock in CLOCK_50 cycles
    // 50 MHz / (2 * 250) gives 100 kHz, inside the 400 kHz init limit
    localparam int unsigned SD_CLK_DIV_DEFAULT = 250;

    // dummy clocks with cmd high before the first command
    // card needs at least 74
    localparam int unsigned DUMMY_CLOCKS_DEFAULT = 80;

    // heartbeat counter width
    // msb toggles about every 0.17 s at 50 MHz
    localparam int unsigned HEARTBEAT_BITS_DEFAULT = 24;

endpackage

// ==== verilog/board_timebase.sv ====
`timescale 1ns/10ps

module board_timebase #(
    parameter int unsigned CLK_DIV        = board_pkg::SD_CLK_DIV_DEFAULT,
    parameter int unsigned HEARTBEAT_BITS = board_pkg::HEARTBEAT_BITS_DEFAULT
) (
    input  logic CLOCK_50,
    input  logic KEY0,
    output logic sd_clk,
    output logic fall_tick,
    output logic led_heartbeat
);

    // +1 keeps the counter at least one bit wide for CLK_DIV of 1
    localparam int unsigned DIV_W = $clog2(CLK_DIV + 1);

    typedef logic [DIV_W-1:0]          div_cnt_t;
    typedef logic [HEARTBEAT_BITS-1:0] beat_cnt_t;

    div_cnt_t  div_cnt;
    beat_cnt_t beat_cnt;
    logic      div_wrap;

    // =======================================================================
    // sd clock divider
    // =======================================================================
    assign div_wrap = (div_cnt == div_cnt_t'(CLK_DIV - 1));

    // toggle every CLK_DIV cycles
    // tick registered with the clock so it lands in the first low cycle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            div_cnt   <= '0;
            sd_clk    <= 1'b0;
            fall_tick <= 1'b0;
        end else begin
            fall_tick <= div_wrap && sd_clk;
            if (div_wrap) begin
                div_cnt <= '0;
                sd_clk  <= ~sd_clk;
            end else begin
                div_cnt <= div_cnt + div_cnt_t'(1);
            end
        end
    end

    // =======================================================================
    // heartbeat
    // =======================================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat_cnt <= '0;
        end else begin
            beat_cnt <= beat_cnt + beat_cnt_t'(1);
        end
    end

    // led follows counter msb
    assign led_heartbeat = beat_cnt[HEARTBEAT_BITS-1];

    // serializer relies on the tick sitting in the low half period
    a_tick_low : assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        fall_tick |-> !sd_clk);

endmodule

// ==== verilog/sd_crc7.sv ====
`timescale 1ns/10ps

module sd_crc7 (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  clear,
    input  logic                  shift,
    input  logic                  data_bit,
    output sd_proto_pkg::sd_crc_t crc
);

    import sd_proto_pkg::*;

    logic    feedback;
    sd_crc_t crc_next;

    // ===========================================================================
    // serial lfsr, msb first
    // ===========================================================================
    // incoming bit xor top of register decides whether the poly is applied
    assign feedback = data_bit ^ crc[6];
    assign crc_next = {crc[5:0], 1'b0} ^ (feedback ? SD_CRC_POLY : sd_crc_t'(0));

    // clear wins over shift, frame start has no data bit yet
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (shift) begin
            crc <= crc_next;
        end
    end

    // value is final once the 40th header bit is in

endmodule

// ==== verilog/sd_cmd_serializer.sv ====
`timescale 1ns/10ps

module sd_cmd_serializer #(
    parameter int unsigned DUMMY_CLOCKS = board_pkg::DUMMY_CLOCKS_DEFAULT
) (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  fall_tick,
    input  logic                  xfer_req,
    input  sd_proto_pkg::sd_req_t xfer,
    output logic                  xfer_ack,
    output logic                  sd_cmd_out,
    output logic                  sd_cmd_oe
);

    import sd_proto_pkg::*;

    // counter must hold the longer of preamble and frame
    localparam int unsigned MAX_BITS =
        (DUMMY_CLOCKS > SD_FRAME_BITS) ? DUMMY_CLOCKS : SD_FRAME_BITS;
    localparam int unsigned CNT_W = $clog2(MAX_BITS + 1);

    typedef logic [CNT_W-1:0]           bit_cnt_t;
    // start, transmission, index and argument
    typedef logic [SD_FRAME_BITS-9:0]   head_t;
    typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_ACK} ser_state_t;

    // remaining-count values where the frame changes field
    localparam bit_cnt_t CNT_CRC_FIRST = bit_cnt_t'(8);
    localparam bit_cnt_t CNT_END       = bit_cnt_t'(1);

    ser_state_t state;
    bit_cnt_t   bit_cnt;
    head_t      shreg;
    logic       preamble;
    logic       load;
    logic       crc_shift;
    logic       next_bit;
    logic [2:0] crc_sel;
    sd_crc_t    crc;

    // ===========================================================================
    // frame control
    // ===========================================================================
    assign load      = (state == ST_IDLE) && xfer_req;
    // header bits only, crc and end bit do not feed the lfsr
    assign crc_shift = (state == ST_SHIFT) && fall_tick && !preamble &&
                       (bit_cnt > CNT_CRC_FIRST);
    // count 8 down to 2 walks crc bit 6 down to 0
    assign crc_sel   = 3'(bit_cnt - bit_cnt_t'(2));

    always_comb begin
        if (preamble || (bit_cnt == CNT_END)) begin
            next_bit = 1'b1;
        end else if (bit_cnt > CNT_CRC_FIRST) begin
            next_bit = shreg[$high(shreg)];
        end else begin
            next_bit = crc[crc_sel];
        end
    end

    // one bit per falling sd clock edge
    // one extra tick after the last bit to release the line and ack
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= ST_IDLE;
            bit_cnt    <= '0;
            preamble   <= 1'b0;
            xfer_ack   <= 1'b0;
            sd_cmd_out <= 1'b1;
            sd_cmd_oe  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (xfer_req) begin
                        preamble <= xfer.preamble;
                        bit_cnt  <= xfer.preamble ? bit_cnt_t'(DUMMY_CLOCKS)
                                                  : bit_cnt_t'(SD_FRAME_BITS);
                        state    <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    if (fall_tick) begin
                        if (bit_cnt == '0) begin
                            sd_cmd_oe  <= 1'b0;
                            sd_cmd_out <= 1'b1;
                            xfer_ack   <= 1'b1;
                            state      <= ST_ACK;
                        end else begin
                            sd_cmd_oe  <= 1'b1;
                            sd_cmd_out <= next_bit;
                            bit_cnt    <= bit_cnt - bit_cnt_t'(1);
                        end
                    end
                end
                ST_ACK: begin
                    // hold ack until requester lets go
                    if (!xfer_req) begin
                        xfer_ack <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // header shift register
    always_ff @(posedge CLOCK_50) begin
        if (load) begin
            shreg <= {1'b0, 1'b1, xfer.cmd};
        end else if (crc_shift) begin
            shreg <= {shreg[$high(shreg)-1:0], 1'b0};
        end
    end

    sd_crc7 i_crc7 (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .clear    (load),
        .shift    (crc_shift),
        .data_bit (shreg[$high(shreg)]),
        .crc      (crc)
    );

    // ack only answers a live request
    a_ack_needs_req : assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(xfer_ack) |-> xfer_req);

    // line released whenever no transfer is running
    a_idle_released : assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (state == ST_IDLE) |-> !sd_cmd_oe);

endmodule

// ==== verilog/sd_init_sequencer.sv ====
`timescale 1ns/10ps

module sd_init_sequencer (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    output logic                  xfer_req,
    output sd_proto_pkg::sd_req_t xfer,
    input  logic                  xfer_ack,
    output logic                  sd_cs,
    output logic                  dbg_req,
    output board_pkg::dbg_char_t  dbg_char,
    input  logic                  dbg_ack
);

    import sd_proto_pkg::*;
    import board_pkg::*;

    typedef enum logic [3:0] {
        ST_PREAMBLE,
        ST_CMD0,
        ST_PUT0,
        ST_CMD55,
        ST_PUT5,
        ST_ACMD41,
        ST_PUTA,
        ST_PUTD,
        ST_DONE
    } seq_state_t;

    // issue raises the request, release waits for ack to drop
    typedef enum logic {PH_ISSUE, PH_RELEASE} phase_t;

    seq_state_t state;
    seq_state_t next_state;
    phase_t     phase;
    logic       is_char;
    logic       hs_req;
    logic       hs_ack;

    // ===========================================================================
    // per-state payload
    // ===========================================================================
    // payloads come straight from state, so stable across each handshake
    always_comb begin
        xfer       = '0;
        dbg_char   = dbg_char_t'(0);
        next_state = ST_DONE;
        case (state)
            ST_PREAMBLE: begin
                xfer.preamble = 1'b1;
                next_state    = ST_CMD0;
            end
            ST_CMD0: begin
                xfer.cmd   = '{index: SD_CMD0, arg: sd_arg_t'(0)};
                next_state = ST_PUT0;
            end
            ST_PUT0: begin
                dbg_char   = "0";
                next_state = ST_CMD55;
            end
            ST_CMD55: begin
                xfer.cmd   = '{index: SD_CMD55, arg: sd_arg_t'(0)};
                next_state = ST_PUT5;
            end
            ST_PUT5: begin
                dbg_char   = "5";
                next_state = ST_ACMD41;
            end
            ST_ACMD41: begin
                xfer.cmd   = '{index: SD_ACMD41, arg: SD_ACMD41_ARG};
                next_state = ST_PUTA;
            end
            ST_PUTA: begin
                dbg_char   = "A";
                next_state = ST_PUTD;
            end
            ST_PUTD: begin
                dbg_char   = "D";
                next_state = ST_DONE;
            end
            default: next_state = ST_DONE;
        endcase
    end

    // cs deasserted only for the dummy clocks
    assign sd_cs = (state == ST_PREAMBLE);

    // pick which link the current state talks to
    assign is_char = (state == ST_PUT0) || (state == ST_PUT5) ||
                     (state == ST_PUTA) || (state == ST_PUTD);
    assign hs_req  = is_char ? dbg_req : xfer_req;
    assign hs_ack  = is_char ? dbg_ack : xfer_ack;

    // ===========================================================================
    // four-phase handshake FSM
    // ===========================================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= ST_PREAMBLE;
            phase    <= PH_ISSUE;
            xfer_req <= 1'b0;
            dbg_req  <= 1'b0;
        end else if (state != ST_DONE) begin
            case (phase)
                PH_ISSUE: begin
                    if (hs_req && hs_ack) begin
                        xfer_req <= 1'b0;
                        dbg_req  <= 1'b0;
                        phase    <= PH_RELEASE;
                    end else if (!hs_req && !hs_ack) begin
                        // new request only once the far side is idle
                        if (is_char) begin
                            dbg_req <= 1'b1;
                        end else begin
                            xfer_req <= 1'b1;
                        end
                    end
                end
                PH_RELEASE: begin
                    if (!hs_ack) begin
                        state <= next_state;
                        phase <= PH_ISSUE;
                    end
                end
                default: phase <= PH_ISSUE;
            endcase
        end
    end

    // debug sink may sample the character any time during the request
    a_char_stable : assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (dbg_req && $past(dbg_req)) |-> $stable(dbg_char));

endmodule

// ==== verilog/sd_init_top.sv ====
`timescale 1ns/10ps

module sd_init_top #(
    parameter int unsigned CLK_DIV        = board_pkg::SD_CLK_DIV_DEFAULT,
    parameter int unsigned DUMMY_CLOCKS   = board_pkg::DUMMY_CLOCKS_DEFAULT,
    parameter int unsigned HEARTBEAT_BITS = board_pkg::HEARTBEAT_BITS_DEFAULT
) (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    output logic                 led_heartbeat,
    output logic                 sd_clk,
    output logic                 sd_cmd_out,
    output logic                 sd_cmd_oe,
    output logic                 sd_cs,
    output logic                 dbg_req,
    output board_pkg::dbg_char_t dbg_char,
    input  logic                 dbg_ack
);

    import sd_proto_pkg::*;

    logic    fall_tick;
    logic    xfer_req;
    logic    xfer_ack;
    sd_req_t xfer;

    // ===========================================================================
    // clocking and heartbeat
    // ===========================================================================
    board_timebase #(
        .CLK_DIV        (CLK_DIV),
        .HEARTBEAT_BITS (HEARTBEAT_BITS)
    ) i_timebase (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .sd_clk        (sd_clk),
        .fall_tick     (fall_tick),
        .led_heartbeat (led_heartbeat)
    );

    // ===========================================================================
    // command ordering and cmd line
    // ===========================================================================
    sd_init_sequencer i_sequencer (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .xfer_req (xfer_req),
        .xfer     (xfer),
        .xfer_ack (xfer_ack),
        .sd_cs    (sd_cs),
        .dbg_req  (dbg_req),
        .dbg_char (dbg_char),
        .dbg_ack  (dbg_ack)
    );

    // oe and out stay split, pad tristate sits outside this block
    sd_cmd_serializer #(
        .DUMMY_CLOCKS (DUMMY_CLOCKS)
    ) i_serializer (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .fall_tick  (fall_tick),
        .xfer_req   (xfer_req),
        .xfer       (xfer),
        .xfer_ack   (xfer_ack),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe)
    );

endmodule

// ==== verification/tb_sd_init.sv ====
`timescale 1ns/10ps

module tb_sd_init;

    import board_pkg::*;

    // ========================================================================
    // run parameters
    // ========================================================================
    localparam int CLK_DIV        = 2;
    localparam int DUMMY_CLOCKS   = 80;
    localparam int HEARTBEAT_BITS = 6;
    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 8;
    localparam int IDLE_CYCLES    = 200;
    localparam int TABLE_LEN      = 8;
    localparam logic [31:0] SEED  = 32'd71793;

    // preamble plus three frames of 49 sd periods, slack, four char handshakes
    localparam int SEQ_CYCLES     = (DUMMY_CLOCKS + 3 * 49 + 20) * 2 * CLK_DIV + 4 * 16;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + SEQ_CYCLES + IDLE_CYCLES;

    typedef enum logic [1:0] {EV_PREAMBLE, EV_FRAME, EV_CHAR} ev_kind_t;

    // one observed or expected event on the pins
    typedef struct packed {
        ev_kind_t    kind;
        logic [47:0] value;
    } seq_event_t;

    logic      CLOCK_50;
    logic      KEY0;
    logic      led_heartbeat;
    logic      sd_clk;
    logic      sd_cmd_out;
    logic      sd_cmd_oe;
    logic      sd_cs;
    logic      dbg_req;
    dbg_char_t dbg_char;
    logic      dbg_ack;

    seq_event_t  exp_table [TABLE_LEN];
    string       exp_names [TABLE_LEN];
    seq_event_t  ev_queue [$];
    logic [31:0] rng_state;
    int          error_count;
    int          test_err_base;
    int          tests_passed;
    int          tests_failed;

    sd_init_top #(
        .CLK_DIV        (CLK_DIV),
        .DUMMY_CLOCKS   (DUMMY_CLOCKS),
        .HEARTBEAT_BITS (HEARTBEAT_BITS)
    ) i_dut (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .led_heartbeat (led_heartbeat),
        .sd_clk        (sd_clk),
        .sd_cmd_out    (sd_cmd_out),
        .sd_cmd_oe     (sd_cmd_oe),
        .sd_cs         (sd_cs),
        .dbg_req       (dbg_req),
        .dbg_char      (dbg_char),
        .dbg_ack       (dbg_ack)
    );

    // ========================================================================
    // reference model of the frame format
    // ========================================================================
    // crc7 over x^7 + x^3 + 1, msb first
    function automatic logic [6:0] crc7_of(input logic [39:0] head);
        logic [6:0] crc;
        logic       fb;
        crc = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            fb  = head[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    // start 0, transmission 1, index, arg, crc, end 1
    function automatic logic [47:0] build_frame(input logic [5:0] idx, input logic [31:0] arg);
        logic [39:0] head;
        head = {2'b01, idx, arg};
        return {head, crc7_of(head), 1'b1};
    endfunction

    function automatic seq_event_t make_event(input ev_kind_t kind, input logic [47:0] value);
        seq_event_t ev;
        ev.kind  = kind;
        ev.value = value;
        return ev;
    endfunction

    function automatic string value_name(input ev_kind_t kind);
        case (kind)
            EV_PREAMBLE: return "preamble bit count";
            EV_FRAME:    return "cmd frame";
            default:     return "dbg_char";
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected order on the pins
    task automatic load_table();
        exp_table[0] = make_event(EV_PREAMBLE, 48'(DUMMY_CLOCKS));
        exp_table[1] = make_event(EV_FRAME, build_frame(6'd0, 32'h0000_0000));
        exp_table[2] = make_event(EV_CHAR, 48'(8'h30));
        exp_table[3] = make_event(EV_FRAME, build_frame(6'd55, 32'h0000_0000));
        exp_table[4] = make_event(EV_CHAR, 48'(8'h35));
        exp_table[5] = make_event(EV_FRAME, build_frame(6'd41, 32'h4000_0000));
        exp_table[6] = make_event(EV_CHAR, 48'(8'h41));
        exp_table[7] = make_event(EV_CHAR, 48'(8'h44));
        exp_names    = '{"preamble", "CMD0", "char 0", "CMD55", "char 5",
                         "ACMD41", "char A", "char D"};
    endtask

    // ========================================================================
    // reporting
    // ========================================================================
    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        error_count = error_count + 1;
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t: %s", $time, what);
        error_count = error_count + 1;
    endtask

    task automatic start_test();
        test_err_base = error_count;
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_err_base) begin
            tests_passed = tests_passed + 1;
            $display("test %s: pass", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: fail", name);
        end
    endtask

    task automatic check_reset_outputs();
        if (dbg_req !== 1'b0) begin
            report_mismatch("dbg_req", 64'd0, 64'(dbg_req));
        end
        if (sd_cmd_oe !== 1'b0) begin
            report_mismatch("sd_cmd_oe", 64'd0, 64'(sd_cmd_oe));
        end
        if (led_heartbeat !== 1'b0) begin
            report_mismatch("led_heartbeat", 64'd0, 64'(led_heartbeat));
        end
        if (sd_cmd_out !== 1'b1) begin
            report_mismatch("sd_cmd_out", 64'd1, 64'(sd_cmd_out));
        end
        if (sd_cs !== 1'b1) begin
            report_mismatch("sd_cs", 64'd1, 64'(sd_cs));
        end
    endtask

    // cycles up to the next sd_clk rise, or next led toggle
    task automatic wait_for_edge(input bit use_led, output int cycles);
        logic prev;
        logic cur;
        logic seen;
        prev   = use_led ? led_heartbeat : sd_clk;
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(negedge CLOCK_50);
            cycles = cycles + 1;
            cur    = use_led ? led_heartbeat : sd_clk;
            seen   = use_led ? (cur != prev) : (cur && !prev);
            prev   = cur;
        end
    endtask

    // ========================================================================
    // clock and watchdog
    // ========================================================================
    initial begin : clock_gen
        CLOCK_50 = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge CLOCK_50);
            cycles = cycles + 1;
        end
        $display("Timeout: run did not complete within %0d cycles", cycles);
        $display("TB FAILED");
        $finish;
    end

    // ========================================================================
    // cmd line decoder
    // ========================================================================
    // sampled at the negedge after each sd_clk rise, one run per oe-high window
    initial begin : frame_decoder
        logic        clk_prev;
        logic        in_run;
        logic        first_bit;
        logic        cs_flagged;
        int          nbits;
        logic [47:0] bits;
        clk_prev   = 1'b0;
        in_run     = 1'b0;
        first_bit  = 1'b0;
        cs_flagged = 1'b0;
        nbits      = 0;
        bits       = '0;
        forever begin
            @(negedge CLOCK_50);
            if (sd_clk && !clk_prev) begin
                if (sd_cmd_oe) begin
                    if (!in_run) begin
                        in_run     = 1'b1;
                        first_bit  = sd_cmd_out;
                        cs_flagged = 1'b0;
                        nbits      = 0;
                    end
                    bits  = {bits[46:0], sd_cmd_out};
                    nbits = nbits + 1;
                    // leading one marks the preamble
                    if (first_bit && !sd_cmd_out) begin
                        report_failure("zero bit inside the preamble");
                    end
                    // cs high for preamble, low for frames
                    if ((sd_cs !== first_bit) && !cs_flagged) begin
                        report_mismatch("sd_cs", 64'(first_bit), 64'(sd_cs));
                        cs_flagged = 1'b1;
                    end
                end else if (in_run) begin
                    in_run = 1'b0;
                    if (!first_bit && (nbits != 48)) begin
                        report_failure($sformatf("frame of %0d bits instead of 48", nbits));
                    end
                    ev_queue.push_back(make_event(first_bit ? EV_PREAMBLE : EV_FRAME,
                                                  first_bit ? 48'(nbits) : bits));
                end
            end
            clk_prev = sd_clk;
        end
    end

    // ========================================================================
    // debug port responder
    // ========================================================================
    initial begin : dbg_responder
        dbg_char_t held;
        int        delay;
        dbg_ack   = 1'b0;
        rng_state = SEED;
        forever begin
            @(negedge CLOCK_50);
            if (KEY0 && dbg_req && !dbg_ack) begin
                held = dbg_char;
                ev_queue.push_back(make_event(EV_CHAR, 48'(held)));
                rng_state = xorshift32(rng_state);
                delay     = int'(rng_state[2:0]);
                // back-pressure window
                repeat (delay) begin
                    @(negedge CLOCK_50);
                    if (!dbg_req) begin
                        report_failure("dbg_req fell before dbg_ack was given");
                    end
                    if (dbg_char !== held) begin
                        report_mismatch("dbg_char", 64'(held), 64'(dbg_char));
                    end
                    if (sd_cmd_oe) begin
                        report_failure("frame started during an open character handshake");
                    end
                end
                dbg_ack = 1'b1;
                do begin
                    @(negedge CLOCK_50);
                    if (sd_cmd_oe) begin
                        report_failure("frame started during an open character handshake");
                    end
                    if (dbg_req && (dbg_char !== held)) begin
                        report_mismatch("dbg_char", 64'(held), 64'(dbg_char));
                    end
                end while (dbg_req);
                dbg_ack = 1'b0;
            end
        end
    end

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin : main_sequence
        seq_event_t got;
        int         cycles;
        logic       idle_flagged;
        KEY0          = 1'b0;
        error_count   = 0;
        test_err_base = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        load_table();

        start_test();
        repeat (4) begin
            @(negedge CLOCK_50);
        end
        check_reset_outputs();
        if (sd_clk !== 1'b0) begin
            report_mismatch("sd_clk", 64'd0, 64'(sd_clk));
        end
        repeat (RESET_CYCLES - 4) begin
            @(negedge CLOCK_50);
        end
        KEY0 = 1'b1;
        @(negedge CLOCK_50);
        check_reset_outputs();
        finish_test("reset values");

        start_test();
        wait_for_edge(1'b0, cycles);
        wait_for_edge(1'b0, cycles);
        if (cycles != 2 * CLK_DIV) begin
            report_mismatch("sd_clk period", 64'(2 * CLK_DIV), 64'(cycles));
        end
        finish_test("sd_clk period");

        start_test();
        wait_for_edge(1'b1, cycles);
        wait_for_edge(1'b1, cycles);
        if (cycles != 2 ** (HEARTBEAT_BITS - 1)) begin
            report_mismatch("led_heartbeat half period", 64'(2 ** (HEARTBEAT_BITS - 1)),
                            64'(cycles));
        end
        finish_test("heartbeat period");

        // known crc bytes of the first two commands
        start_test();
        if (exp_table[1].value != 48'h4000_0000_0095) begin
            report_mismatch("CMD0 reference", 64'h4000_0000_0095, 64'(exp_table[1].value));
        end
        if (exp_table[3].value != 48'h7700_0000_0065) begin
            report_mismatch("CMD55 reference", 64'h7700_0000_0065, 64'(exp_table[3].value));
        end
        finish_test("reference frames");

        // events are buffered by the monitors, walk them in order
        for (int i = 0; i < TABLE_LEN; i++) begin
            start_test();
            while (ev_queue.size() == 0) begin
                @(negedge CLOCK_50);
            end
            got = ev_queue.pop_front();
            if (got.kind != exp_table[i].kind) begin
                report_mismatch("event kind", 64'(exp_table[i].kind), 64'(got.kind));
            end else if (got.value != exp_table[i].value) begin
                report_mismatch(value_name(got.kind), 64'(exp_table[i].value), 64'(got.value));
            end
            finish_test(exp_names[i]);
        end

        // wait for the last handshake to close, then all quiet
        start_test();
        while (dbg_req || dbg_ack) begin
            @(negedge CLOCK_50);
        end
        idle_flagged = 1'b0;
        repeat (IDLE_CYCLES) begin
            @(negedge CLOCK_50);
            if ((sd_cmd_oe || dbg_req) && !idle_flagged) begin
                report_failure("cmd line or dbg_req active after the final handshake");
                idle_flagged = 1'b1;
            end
        end
        if (ev_queue.size() != 0) begin
            report_failure("extra transfers after the last expected event");
        end
        finish_test("idle after D");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/sd_proto_pkg.sv
verilog/board_pkg.sv
verilog/board_timebase.sv
verilog/sd_crc7.sv
verilog/sd_cmd_serializer.sv
verilog/sd_init_sequencer.sv
verilog/sd_init_top.sv
verification/tb_sd_init.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sd_init
VFLAGS    ?= --assert -j 0
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

SOURCES := $(shell cat tb.f)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) tb.f
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || echo "TB FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
